/* list.f */
verilog/rv_isa_pkg.sv
verilog/core_pkg.sv
verilog/pc_unit.sv
verilog/insn_decoder.sv
verilog/reg_file.sv
verilog/alu_exec.sv
verilog/lsu.sv
verilog/rv_core.sv
verification/rv_core_props.sv
verification/rv_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/rv_core_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1

/* verification/rv_core_props.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core_props (
  input logic                clk,
  input logic                rst,
  input core_pkg::word_t     imem_addr_i,
  input core_pkg::dmem_req_t dmem_req_i,
  input logic                halt_i
);
  import core_pkg::*;

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
    imem_addr_i[1:0] == 2'b00)
    else $error("pc not word aligned");

  a_no_store_idle: assert property (@(posedge clk)
    (halt_i || rst) |-> dmem_req_i.be == 4'b0000)
    else $error("store enable while halted or in reset");

  a_halt_sticky: assert property (@(posedge clk) disable iff (rst)
    halt_i |=> halt_i)
    else $error("halt dropped without reset");

  a_pc_frozen: assert property (@(posedge clk) disable iff (rst)
    halt_i |=> $stable(imem_addr_i))
    else $error("pc moved while halted");

endmodule

bind rv_core rv_core_props u_props (
  .clk        (clk),
  .rst        (rst),
  .imem_addr_i(imem_addr_o),
  .dmem_req_i (dmem_req_o),
  .halt_i     (halt_o)
);

`default_nettype wire

/* verification/rv_core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core_tb;
  import core_pkg::*;

  localparam word_t RESET_PC     = 32'h0000_0080;
  localparam int    RESET_CYCLES = 10;
  localparam int    BASE_IDX     = 256;

  // major opcodes as listed in the RV32I base encoding table
  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_IMM    = 7'h13;
  localparam logic [6:0] OPC_AUIPC  = 7'h17;
  localparam logic [6:0] OPC_STORE  = 7'h23;
  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_BRANCH = 7'h63;
  localparam logic [6:0] OPC_JALR   = 7'h67;
  localparam logic [6:0] OPC_JAL    = 7'h6F;
  localparam logic [31:0] ECALL     = 32'h0000_0073;

  logic      clk;
  logic      rst;
  word_t     imem_addr;
  word_t     imem_rdata;
  dmem_req_t dmem_req;
  word_t     dmem_rdata;
  logic      halt;

  logic [31:0] imem [1024];
  logic [31:0] dmem [1024];
  logic [31:0] expect_q [$];

  logic        mem_init;
  logic        preload_en;
  logic [9:0]  preload_idx;
  logic [31:0] preload_val;
  int          prog_len;
  int          store_count;
  int          cycles;
  int          cycle_limit;
  int          checks;
  int          errors;
  integer      seed;

  rv_core #(
    .RESET_PC(RESET_PC)
  ) u_dut (
    .clk         (clk),
    .rst         (rst),
    .imem_addr_o (imem_addr),
    .imem_rdata_i(imem_rdata),
    .dmem_req_o  (dmem_req),
    .dmem_rdata_i(dmem_rdata),
    .halt_o      (halt)
  );

  // both memories answer within the cycle
  assign imem_rdata = imem[imem_addr[11:2]];
  assign dmem_rdata = dmem[dmem_req.addr[11:2]];

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] fill_word(input int idx);
    return (32'h9E37_79B1 * (idx + 1)) ^ 32'hC3A5_0F00;
  endfunction

  always @(posedge clk) begin
    if (mem_init) begin
      for (int i = 0; i < 1024; i++) begin
        dmem[10'(i)] <= fill_word(i);
      end
      if (preload_en) begin
        dmem[preload_idx] <= preload_val;
      end
    end else if (dmem_req.be != 4'b0000) begin
      store_count <= store_count + 1;
      for (int b = 0; b < 4; b++) begin
        if (dmem_req.be[b]) begin
          dmem[dmem_req.addr[11:2]][8*b +: 8] <= dmem_req.wdata[8*b +: 8];
        end
      end
    end
  end

  // watchdog limit grows with every program that is run
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: core did not halt within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  function automatic logic [31:0] cur_pc();
    return RESET_PC + 32'(4 * prog_len);
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      3'b111:  return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // halfword lanes only look at offset bit 1
  function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [31:0] data,
                                              input logic [1:0] off, input logic [2:0] f3);
    logic [4:0] sh;
    case (f3)
      3'b000: begin
        sh = {off, 3'b000};
        return (old & ~(32'h0000_00FF << sh)) | ({24'h0, data[7:0]} << sh);
      end
      3'b001: begin
        sh = {off[1], 4'b0000};
        return (old & ~(32'h0000_FFFF << sh)) | ({16'h0, data[15:0]} << sh);
      end
      default: return data;
    endcase
  endfunction

  function automatic logic [31:0] load_value(input logic [31:0] w, input logic [1:0] off,
                                             input logic [2:0] f3);
    logic [7:0]  b8;
    logic [15:0] h16;
    b8  = 8'(w >> {off, 3'b000});
    h16 = 16'(w >> {off[1], 4'b0000});
    case (f3)
      3'b000:  return {{24{b8[7]}}, b8};
      3'b100:  return {24'h0, b8};
      3'b001:  return {{16{h16[15]}}, h16};
      3'b101:  return {16'h0, h16};
      default: return w;
    endcase
  endfunction

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Fail %s: got %h, expected %h", what, got, exp);
      errors++;
    end
  endtask

  task automatic start_prog();
    for (int i = 0; i < 1024; i++) begin
      imem[10'(i)] = ECALL;
    end
    prog_len   = 0;
    preload_en = 1'b0;
    expect_q.delete();
  endtask

  task automatic emit(input logic [31:0] insn);
    imem[10'((RESET_PC >> 2) + 32'(prog_len))] = insn;
    prog_len++;
  endtask

  // x31 holds the data base address 0x400
  task automatic set_base();
    emit(enc_i(12'h400, 5'd0, 3'b000, 5'd31, OPC_IMM));
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] t;
    t = v + 32'h800;
    emit({t[31:12], rd, OPC_LUI});
    emit(enc_i(v[11:0], rd, 3'b000, rd, OPC_IMM));
  endtask

  // one result slot per word, starting at the base
  task automatic store_at(input logic [2:0] f3, input logic [4:0] rs, input logic [1:0] off,
                          input logic [31:0] exp);
    emit(enc_s(12'(expect_q.size() * 4 + int'(off)), rs, 5'd31, f3));
    expect_q.push_back(exp);
  endtask

  task automatic run_prog();
    cycle_limit = cycle_limit + prog_len + RESET_CYCLES + 40;
    @(posedge clk);
    rst      <= 1'b1;
    mem_init <= 1'b1;
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(negedge clk);
      if (i > 0) begin
        check_word("imem_addr_o in reset", imem_addr, RESET_PC);
        check_word("dmem be in reset", {28'h0, dmem_req.be}, 32'h0);
      end
      @(posedge clk);
      mem_init <= 1'b0;
    end
    rst <= 1'b0;
    do begin
      @(negedge clk);
    end while (halt !== 1'b1);
  endtask

  task automatic check_slots();
    for (int n = 0; n < expect_q.size(); n++) begin
      check_word($sformatf("dmem[%0d]", BASE_IDX + n), dmem[10'(BASE_IDX + n)], expect_q[n]);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("%-12s %s, %0d errors", name, (errors == errs_before) ? "ok" : "FAIL",
             errors - errs_before);
  endtask

  task automatic test_reset_halt();
    int          errs_before;
    logic [31:0] ecall_pc;
    word_t       pc_held;
    int          stores_held;
    errs_before = errors;
    start_prog();
    set_base();
    emit(enc_i(12'h05A, 5'd0, 3'b000, 5'd1, OPC_IMM));
    store_at(3'b010, 5'd1, 2'd0, 32'h5A);
    ecall_pc = cur_pc();
    emit(ECALL);
    // never reached
    store_at(3'b010, 5'd1, 2'd0, fill_word(BASE_IDX + 1));
    run_prog();
    check_word("imem_addr_o at halt", imem_addr, ecall_pc);
    pc_held     = imem_addr;
    stores_held = store_count;
    repeat (5) @(negedge clk);
    check_word("imem_addr_o while halted", imem_addr, pc_held);
    check_word("halt_o", {31'h0, halt}, 32'h1);
    check_word("store count after halt", 32'(store_count), 32'(stores_held));
    check_slots();
    report_test("reset_halt", errs_before);
  endtask

  task automatic alu_r(input logic [2:0] f3, input logic alt, input logic [31:0] exp);
    emit(enc_r(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3, OPC_OP));
    store_at(3'b010, 5'd3, 2'd0, exp);
  endtask

  task automatic alu_i(input logic [2:0] f3, input logic [11:0] imm, input logic [31:0] exp);
    emit(enc_i(imm, 5'd1, f3, 5'd3, OPC_IMM));
    store_at(3'b010, 5'd3, 2'd0, exp);
  endtask

  task automatic test_alu();
    int          errs_before;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] u;
    logic [31:0] simm;
    logic [11:0] imm;
    logic [4:0]  sh;
    logic [4:0]  shi;
    errs_before = errors;
    for (int round = 0; round < 2; round++) begin
      a    = $random(seed);
      b    = $random(seed);
      u    = $random(seed);
      imm  = 12'($random(seed));
      simm = {{20{imm[11]}}, imm};
      sh   = b[4:0];
      shi  = imm[4:0];
      start_prog();
      set_base();
      load_const(5'd1, a);
      load_const(5'd2, b);
      alu_r(3'b000, 1'b0, a + b);
      alu_r(3'b000, 1'b1, a - b);
      alu_r(3'b001, 1'b0, a << sh);
      alu_r(3'b010, 1'b0, {31'h0, $signed(a) < $signed(b)});
      alu_r(3'b011, 1'b0, {31'h0, a < b});
      alu_r(3'b100, 1'b0, a ^ b);
      alu_r(3'b101, 1'b0, a >> sh);
      alu_r(3'b101, 1'b1, $signed(a) >>> sh);
      alu_r(3'b110, 1'b0, a | b);
      alu_r(3'b111, 1'b0, a & b);
      alu_i(3'b000, imm, a + simm);
      alu_i(3'b010, imm, {31'h0, $signed(a) < $signed(simm)});
      alu_i(3'b011, imm, {31'h0, a < simm});
      alu_i(3'b100, imm, a ^ simm);
      alu_i(3'b110, imm, a | simm);
      alu_i(3'b111, imm, a & simm);
      alu_i(3'b001, {7'h00, shi}, a << shi);
      alu_i(3'b101, {7'h00, shi}, a >> shi);
      alu_i(3'b101, {7'h20, shi}, $signed(a) >>> shi);
      emit({u[19:0], 5'd3, OPC_LUI});
      store_at(3'b010, 5'd3, 2'd0, {u[19:0], 12'h000});
      store_at(3'b010, 5'd0, 2'd0, 32'h0);
      emit({u[31:12], 5'd4, OPC_AUIPC});
      store_at(3'b010, 5'd4, 2'd0, cur_pc() - 32'd4 + {u[31:12], 12'h000});
      emit(ECALL);
      run_prog();
      check_slots();
    end
    report_test("alu", errs_before);
  endtask

  task automatic test_control();
    int          errs_before;
    logic [4:0]  ra [3];
    logic [4:0]  rb [3];
    logic [2:0]  f3s [6];
    logic [31:0] va;
    logic [31:0] vb;
    logic [31:0] jump_pc;
    errs_before = errors;
    ra  = '{5'd1, 5'd2, 5'd1};
    rb  = '{5'd2, 5'd1, 5'd1};
    f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    start_prog();
    set_base();
    load_const(5'd1, 32'hFFFF_FFFD);
    load_const(5'd2, 32'h0000_0005);
    emit(enc_i(12'h055, 5'd0, 3'b000, 5'd5, OPC_IMM));
    // a taken branch skips its marker store
    for (int p = 0; p < 3; p++) begin
      va = (ra[p] == 5'd1) ? 32'hFFFF_FFFD : 32'h5;
      vb = (rb[p] == 5'd1) ? 32'hFFFF_FFFD : 32'h5;
      for (int k = 0; k < 6; k++) begin
        emit(enc_b(13'd8, rb[p], ra[p], f3s[k]));
        store_at(3'b010, 5'd5, 2'd0,
                 branch_taken(f3s[k], va, vb) ? fill_word(BASE_IDX + expect_q.size()) :
                                                32'h55);
      end
    end
    jump_pc = cur_pc();
    emit(enc_j(21'd8, 5'd6));
    store_at(3'b010, 5'd5, 2'd0, fill_word(BASE_IDX + expect_q.size()));
    store_at(3'b010, 5'd6, 2'd0, jump_pc + 32'd4);
    // jalr target gets bit 0 cleared
    jump_pc = cur_pc() + 32'd8;
    load_const(5'd7, jump_pc + 32'd8);
    emit(enc_i(12'h001, 5'd7, 3'b000, 5'd8, OPC_JALR));
    store_at(3'b010, 5'd5, 2'd0, fill_word(BASE_IDX + expect_q.size()));
    store_at(3'b010, 5'd8, 2'd0, jump_pc + 32'd4);
    emit(ECALL);
    run_prog();
    check_slots();
    report_test("control", errs_before);
  endtask

  task automatic test_stores();
    int          errs_before;
    logic [31:0] v;
    errs_before = errors;
    v = $random(seed);
    start_prog();
    set_base();
    load_const(5'd1, v);
    for (int off = 0; off < 4; off++) begin
      store_at(3'b000, 5'd1, 2'(off),
               merge_store(fill_word(BASE_IDX + expect_q.size()), v, 2'(off), 3'b000));
    end
    for (int off = 0; off < 4; off++) begin
      store_at(3'b001, 5'd1, 2'(off),
               merge_store(fill_word(BASE_IDX + expect_q.size()), v, 2'(off), 3'b001));
    end
    store_at(3'b010, 5'd1, 2'd0, v);
    emit(ECALL);
    run_prog();
    check_slots();
    report_test("stores", errs_before);
  endtask

  task automatic test_loads();
    int          errs_before;
    logic [31:0] w;
    logic [2:0]  f3s [5];
    errs_before = errors;
    w   = 32'h80F2_7FE4;
    f3s = '{3'b000, 3'b100, 3'b001, 3'b101, 3'b010};
    start_prog();
    preload_en  = 1'b1;
    preload_idx = 10'(BASE_IDX);
    preload_val = w;
    expect_q.push_back(w);
    set_base();
    for (int k = 0; k < 5; k++) begin
      for (int off = 0; off < 4; off++) begin
        emit(enc_i(12'(off), 5'd31, f3s[k], 5'd3, OPC_LOAD));
        store_at(3'b010, 5'd3, 2'd0, load_value(w, 2'(off), f3s[k]));
      end
    end
    emit(ECALL);
    run_prog();
    check_slots();
    report_test("loads", errs_before);
  endtask

  task automatic test_x0();
    int errs_before;
    errs_before = errors;
    start_prog();
    set_base();
    load_const(5'd0, 32'h1234_5678);
    emit(enc_i(12'h07B, 5'd0, 3'b000, 5'd0, OPC_IMM));
    store_at(3'b010, 5'd0, 2'd0, 32'h0);
    load_const(5'd2, 32'h0000_DEAD);
    emit(enc_r(7'h00, 5'd2, 5'd2, 3'b000, 5'd0, OPC_OP));
    emit(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd1, OPC_OP));
    store_at(3'b010, 5'd0, 2'd0, 32'h0);
    store_at(3'b010, 5'd1, 2'd0, 32'h0);
    emit(ECALL);
    run_prog();
    check_slots();
    report_test("x0", errs_before);
  endtask

  initial begin
    rst         = 1'b1;
    mem_init    = 1'b0;
    preload_en  = 1'b0;
    preload_idx = '0;
    preload_val = '0;
    store_count = 0;
    cycles      = 0;
    cycle_limit = 50;
    checks      = 0;
    errors      = 0;
    seed        = 28006;
    start_prog();
    test_reset_halt();
    test_alu();
    test_control();
    test_stores();
    test_loads();
    test_x0();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/alu_exec.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_exec (
  input  core_pkg::ctrl_t ctrl_i,
  input  core_pkg::word_t pc_i,
  input  core_pkg::word_t imm_i,
  input  core_pkg::word_t rs1_data_i,
  input  core_pkg::word_t rs2_data_i,
  output core_pkg::word_t result_o,
  output core_pkg::word_t link_o,
  output core_pkg::word_t target_o,
  output logic            redirect_o
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  word_t      op_a;
  word_t      op_b;
  word_t      jalr_sum;
  logic [4:0] shamt;
  logic       taken;

  assign op_a  = ctrl_i.src_a_pc ? pc_i : rs1_data_i;
  assign op_b  = ctrl_i.src_b_imm ? imm_i : rs2_data_i;
  assign shamt = op_b[4:0];

  always_comb begin
    case (ctrl_i.alu_op)
      ALU_ADD:    result_o = op_a + op_b;
      ALU_SUB:    result_o = op_a - op_b;
      ALU_SLL:    result_o = op_a << shamt;
      ALU_SLT:    result_o = word_t'($signed(op_a) < $signed(op_b));
      ALU_SLTU:   result_o = word_t'(op_a < op_b);
      ALU_XOR:    result_o = op_a ^ op_b;
      ALU_SRL:    result_o = op_a >> shamt;
      ALU_SRA:    result_o = word_t'($signed(op_a) >>> shamt);
      ALU_OR:     result_o = op_a | op_b;
      ALU_AND:    result_o = op_a & op_b;
      ALU_PASS_B: result_o = op_b;
      default:    result_o = '0;
    endcase
  end

  // branches always compare the two registers
  always_comb begin
    case (ctrl_i.branch_funct3)
      F3_BEQ:  taken = rs1_data_i == rs2_data_i;
      F3_BNE:  taken = rs1_data_i != rs2_data_i;
      F3_BLT:  taken = $signed(rs1_data_i) < $signed(rs2_data_i);
      F3_BGE:  taken = $signed(rs1_data_i) >= $signed(rs2_data_i);
      F3_BLTU: taken = rs1_data_i < rs2_data_i;
      F3_BGEU: taken = rs1_data_i >= rs2_data_i;
      default: taken = 1'b0;
    endcase
  end

  assign link_o   = pc_i + word_t'(4);
  assign jalr_sum = rs1_data_i + imm_i;
  assign target_o = ctrl_i.is_jalr ? {jalr_sum[XLEN-1:1], 1'b0} : pc_i + imm_i;

  assign redirect_o = ctrl_i.is_jal | ctrl_i.is_jalr | (ctrl_i.is_branch & taken);

endmodule

`default_nettype wire

/* verilog/core_pkg.sv */
`default_nettype none

package core_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_LINK
  } wb_sel_e;

  typedef enum logic [1:0] {
    MEM_BYTE,
    MEM_HALF,
    MEM_WORD
  } mem_size_e;

  // decoded control for one instruction
  typedef struct packed {
    alu_op_e    alu_op;
    logic       src_b_imm;
    logic       src_a_pc;
    logic       reg_write;
    wb_sel_e    wb_sel;
    logic       is_load;
    logic       is_store;
    logic       load_unsigned;
    mem_size_e  mem_size;
    logic       is_branch;
    logic [2:0] branch_funct3;
    logic       is_jal;
    logic       is_jalr;
    logic       is_ecall;
  } ctrl_t;

  // addr is word aligned, be selects the written bytes
  typedef struct packed {
    word_t      addr;
    word_t      wdata;
    logic [3:0] be;
  } dmem_req_t;

endpackage

`default_nettype wire

/* verilog/insn_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module insn_decoder (
  input  rv_isa_pkg::insn_u  insn_i,
  input  logic               halted_i,
  output core_pkg::ctrl_t    ctrl_o,
  output core_pkg::reg_idx_t rs1_o,
  output core_pkg::reg_idx_t rs2_o,
  output core_pkg::reg_idx_t rd_o,
  output core_pkg::word_t    imm_o
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic       alt;
  logic       f7_ok;
  logic       is_ecall;
  alu_op_e    alu_fn;
  mem_size_e  size;
  logic       size_ok;
  ctrl_t      ctrl;
  word_t      imm;

  assign opcode = insn_i.r_fmt.opcode;
  assign funct3 = insn_i.r_fmt.funct3;
  assign rs1_o  = insn_i.r_fmt.rs1;
  assign rs2_o  = insn_i.r_fmt.rs2;
  assign rd_o   = insn_i.r_fmt.rd;

  // funct7 is also imm[11:5] for op_imm shifts
  assign alt   = insn_i.r_fmt.funct7 == F7_ALT;
  assign f7_ok = alt || insn_i.r_fmt.funct7 == F7_BASE;

  assign is_ecall = insn_i.i_fmt.imm == '0 && insn_i.i_fmt.rs1 == '0 &&
                    insn_i.i_fmt.funct3 == '0 && insn_i.i_fmt.rd == '0;

  always_comb begin
    case (funct3)
      F3_SLL:  alu_fn = ALU_SLL;
      F3_SLT:  alu_fn = ALU_SLT;
      F3_SLTU: alu_fn = ALU_SLTU;
      F3_XOR:  alu_fn = ALU_XOR;
      F3_SR:   alu_fn = alt ? ALU_SRA : ALU_SRL;
      F3_OR:   alu_fn = ALU_OR;
      F3_AND:  alu_fn = ALU_AND;
      // addi never subtracts, whatever imm[10] holds
      default: alu_fn = (opcode == OP_OP && alt) ? ALU_SUB : ALU_ADD;
    endcase
  end

  always_comb begin
    size_ok = 1'b1;
    size    = MEM_WORD;
    if (opcode == OP_STORE) begin
      case (funct3)
        F3_SB:   size = MEM_BYTE;
        F3_SH:   size = MEM_HALF;
        F3_SW:   size = MEM_WORD;
        default: size_ok = 1'b0;
      endcase
    end else begin
      case (funct3)
        F3_LB, F3_LBU: size = MEM_BYTE;
        F3_LH, F3_LHU: size = MEM_HALF;
        F3_LW:         size = MEM_WORD;
        default:       size_ok = 1'b0;
      endcase
    end
  end

  always_comb begin
    ctrl = '0;
    ctrl.mem_size      = size;
    ctrl.load_unsigned = funct3[2];
    ctrl.branch_funct3 = funct3;
    imm = {{20{insn_i.i_fmt.imm[11]}}, insn_i.i_fmt.imm};
    case (opcode)
      OP_LUI, OP_AUIPC: begin
        imm = {insn_i.u_fmt.imm_31_12, 12'h000};
        ctrl.reg_write = 1'b1;
        ctrl.src_b_imm = 1'b1;
        ctrl.src_a_pc  = opcode == OP_AUIPC;
        ctrl.alu_op    = (opcode == OP_LUI) ? ALU_PASS_B : ALU_ADD;
      end
      OP_JAL: begin
        imm = {{11{insn_i.j_fmt.imm_20}}, insn_i.j_fmt.imm_20, insn_i.j_fmt.imm_19_12,
               insn_i.j_fmt.imm_11, insn_i.j_fmt.imm_10_1, 1'b0};
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = WB_LINK;
        ctrl.is_jal    = 1'b1;
      end
      OP_JALR: begin
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = WB_LINK;
        ctrl.is_jalr   = 1'b1;
      end
      OP_BRANCH: begin
        imm = {{19{insn_i.b_fmt.imm_12}}, insn_i.b_fmt.imm_12, insn_i.b_fmt.imm_11,
               insn_i.b_fmt.imm_10_5, insn_i.b_fmt.imm_4_1, 1'b0};
        ctrl.is_branch = 1'b1;
      end
      OP_LOAD: begin
        ctrl.reg_write = size_ok;
        ctrl.wb_sel    = WB_LOAD;
        ctrl.is_load   = size_ok;
        ctrl.src_b_imm = 1'b1;
      end
      OP_STORE: begin
        imm = {{20{insn_i.s_fmt.imm_hi[6]}}, insn_i.s_fmt.imm_hi, insn_i.s_fmt.imm_lo};
        ctrl.is_store  = size_ok;
        ctrl.src_b_imm = 1'b1;
      end
      OP_IMM: begin
        ctrl.reg_write = 1'b1;
        ctrl.src_b_imm = 1'b1;
        ctrl.alu_op    = alu_fn;
      end
      OP_OP: begin
        // M extension funct7 falls out as a no-op
        ctrl.reg_write = f7_ok;
        ctrl.alu_op    = alu_fn;
      end
      OP_SYSTEM: ctrl.is_ecall = is_ecall;
      // fence has nothing to order in this core
      OP_MISC_MEM: ctrl.reg_write = 1'b0;
      default: ctrl.reg_write = 1'b0;
    endcase
    if (halted_i) begin
      ctrl = '0;
    end
  end

  assign ctrl_o = ctrl;
  assign imm_o  = imm;

endmodule

`default_nettype wire

/* verilog/lsu.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu (
  input  core_pkg::ctrl_t     ctrl_i,
  input  core_pkg::word_t     addr_i,
  input  core_pkg::word_t     rs2_data_i,
  input  core_pkg::word_t     result_i,
  input  core_pkg::word_t     link_i,
  input  core_pkg::word_t     dmem_rdata_i,
  output core_pkg::dmem_req_t dmem_req_o,
  output logic                rd_we_o,
  output core_pkg::word_t     rd_data_o
);
  import core_pkg::*;

  logic [1:0] lane;
  logic [3:0] be;
  word_t      wdata;
  word_t      byte_sel;
  word_t      half_sel;
  word_t      load_val;

  assign lane = addr_i[1:0];

  // store data is replicated, be picks the lane
  always_comb begin
    case (ctrl_i.mem_size)
      MEM_BYTE: begin
        wdata = {4{rs2_data_i[7:0]}};
        be    = 4'b0001 << lane;
      end
      MEM_HALF: begin
        wdata = {2{rs2_data_i[15:0]}};
        be    = 4'b0011 << {lane[1], 1'b0};
      end
      default: begin
        wdata = rs2_data_i;
        be    = 4'b1111;
      end
    endcase
  end

  assign dmem_req_o.addr  = {addr_i[XLEN-1:2], 2'b00};
  assign dmem_req_o.wdata = wdata;
  assign dmem_req_o.be    = ctrl_i.is_store ? be : 4'b0000;

  // move the addressed lane down to bit 0
  assign byte_sel = dmem_rdata_i >> {lane, 3'b000};
  assign half_sel = dmem_rdata_i >> {lane[1], 4'b0000};

  always_comb begin
    case (ctrl_i.mem_size)
      MEM_BYTE: load_val = ctrl_i.load_unsigned ? {24'h0, byte_sel[7:0]} :
                                                  {{24{byte_sel[7]}}, byte_sel[7:0]};
      MEM_HALF: load_val = ctrl_i.load_unsigned ? {16'h0, half_sel[15:0]} :
                                                  {{16{half_sel[15]}}, half_sel[15:0]};
      default:  load_val = dmem_rdata_i;
    endcase
  end

  always_comb begin
    case (ctrl_i.wb_sel)
      WB_LOAD: rd_data_o = load_val;
      WB_LINK: rd_data_o = link_i;
      default: rd_data_o = result_i;
    endcase
  end

  assign rd_we_o = ctrl_i.reg_write;

endmodule

`default_nettype wire

/* verilog/pc_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module pc_unit #(
  parameter core_pkg::word_t RESET_PC = '0
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            redirect_i,
  input  core_pkg::word_t target_i,
  input  logic            ecall_i,
  output core_pkg::word_t pc_o,
  output logic            halted_o
);
  import core_pkg::*;

  word_t pc_q;
  word_t pc_next;
  logic  halted_q;

  assign pc_next = redirect_i ? target_i : pc_q + word_t'(4);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q     <= RESET_PC;
      halted_q <= 1'b0;
    end else if (!halted_q) begin
      // ecall parks the pc on itself
      if (ecall_i) begin
        halted_q <= 1'b1;
      end else begin
        pc_q <= pc_next;
      end
    end
  end

  assign pc_o     = pc_q;
  assign halted_o = halted_q;

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_file (
  input  logic               clk,
  input  logic               rst,
  input  core_pkg::reg_idx_t rs1_i,
  input  core_pkg::reg_idx_t rs2_i,
  input  core_pkg::reg_idx_t rd_i,
  input  logic               we_i,
  input  core_pkg::word_t    rd_data_i,
  output core_pkg::word_t    rs1_data_o,
  output core_pkg::word_t    rs2_data_o
);
  import core_pkg::*;

  localparam int NUM_REGS = 32;

  word_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && rd_i != '0) begin
      regs[rd_i] <= rd_data_i;
    end
  end

  // x0 reads as zero
  assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

/* verilog/rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core #(
  parameter core_pkg::word_t RESET_PC = '0
) (
  input  logic                clk,
  input  logic                rst,
  output core_pkg::word_t     imem_addr_o,
  input  core_pkg::word_t     imem_rdata_i,
  output core_pkg::dmem_req_t dmem_req_o,
  input  core_pkg::word_t     dmem_rdata_i,
  output logic                halt_o
);
  import core_pkg::*;

  word_t    pc;
  word_t    imm;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    alu_result;
  word_t    link;
  word_t    target;
  word_t    rd_data;
  ctrl_t    ctrl;
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  logic     redirect;
  logic     halted;
  logic     squash;
  logic     rd_we;

  // nothing may write or redirect while in reset or after ecall
  assign squash      = halted | rst;
  assign imem_addr_o = pc;
  assign halt_o      = halted;

  pc_unit #(
    .RESET_PC(RESET_PC)
  ) u_pc (
    .clk       (clk),
    .rst       (rst),
    .redirect_i(redirect),
    .target_i  (target),
    .ecall_i   (ctrl.is_ecall),
    .pc_o      (pc),
    .halted_o  (halted)
  );

  insn_decoder u_dec (
    .insn_i  (imem_rdata_i),
    .halted_i(squash),
    .ctrl_o  (ctrl),
    .rs1_o   (rs1),
    .rs2_o   (rs2),
    .rd_o    (rd),
    .imm_o   (imm)
  );

  reg_file u_rf (
    .clk       (clk),
    .rst       (rst),
    .rs1_i     (rs1),
    .rs2_i     (rs2),
    .rd_i      (rd),
    .we_i      (rd_we),
    .rd_data_i (rd_data),
    .rs1_data_o(rs1_data),
    .rs2_data_o(rs2_data)
  );

  alu_exec u_alu (
    .ctrl_i    (ctrl),
    .pc_i      (pc),
    .imm_i     (imm),
    .rs1_data_i(rs1_data),
    .rs2_data_i(rs2_data),
    .result_o  (alu_result),
    .link_o    (link),
    .target_o  (target),
    .redirect_o(redirect)
  );

  // loads and stores take their effective address from the alu sum
  lsu u_lsu (
    .ctrl_i      (ctrl),
    .addr_i      (alu_result),
    .rs2_data_i  (rs2_data),
    .result_i    (alu_result),
    .link_i      (link),
    .dmem_rdata_i(dmem_rdata_i),
    .dmem_req_o  (dmem_req_o),
    .rd_we_o     (rd_we),
    .rd_data_o   (rd_data)
  );

endmodule

`default_nettype wire

/* verilog/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  // RV32I major opcodes
  typedef enum logic [6:0] {
    OP_LOAD     = 7'b0000011,
    OP_MISC_MEM = 7'b0001111,
    OP_IMM      = 7'b0010011,
    OP_AUIPC    = 7'b0010111,
    OP_STORE    = 7'b0100011,
    OP_OP       = 7'b0110011,
    OP_LUI      = 7'b0110111,
    OP_BRANCH   = 7'b1100011,
    OP_JALR     = 7'b1100111,
    OP_JAL      = 7'b1101111,
    OP_SYSTEM   = 7'b1110011
  } opcode_e;

  // branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // load and store widths
  localparam logic [2:0] F3_LB  = 3'b000;
  localparam logic [2:0] F3_LH  = 3'b001;
  localparam logic [2:0] F3_LW  = 3'b010;
  localparam logic [2:0] F3_LBU = 3'b100;
  localparam logic [2:0] F3_LHU = 3'b101;
  localparam logic [2:0] F3_SB  = 3'b000;
  localparam logic [2:0] F3_SH  = 3'b001;
  localparam logic [2:0] F3_SW  = 3'b010;

  // alu variants, shared by op and op_imm
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_e    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    opcode_e     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    opcode_e    opcode;
  } j_fmt_t;

  // one instruction word, six views
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } insn_u;

endpackage

`default_nettype wire
